//--- all.f
logic/spi_pkg.sv
logic/spi_tx_queue.sv
logic/spi_shift_engine.sv
logic/spi_frame_ctrl.sv
logic/spi_master_top.sv
dv/spi_master_tb.sv

//--- dv/spi_master_tb.sv
`default_nettype none

module spi_master_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import spi_pkg::*;

    localparam int DEPTH = 4;
    // Generous per-byte bound in system cycles
    localparam int BYTE_TIMEOUT = 40;

    logic      clk;
    logic      rst;
    logic      wr_en;
    spi_byte_t wr_data;
    logic      full;
    logic      rx_valid;
    spi_byte_t rx_data;
    logic      miso;
    spi_pins_t spi;

    // Trace columns, one entry per line
    int        trace_id[$];
    spi_byte_t trace_wr[$];
    spi_byte_t trace_slv[$];

    // Scoreboard, holds accepted writes only
    spi_byte_t exp_mosi[$];
    spi_byte_t exp_rx[$];
    spi_byte_t slv_q[$];

    int        rx_count;
    int        error_count;
    int        fall_cnt;
    int        slv_bits;
    spi_byte_t slv_rx;
    logic      prev_sclk;
    logic      in_burst;
    logic      cs_check_due;
    logic      cs_expect_high;

    spi_master_top #(
        .clk_div(1),
        .depth  (DEPTH)
    ) uut (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .full    (full),
        .rx_valid(rx_valid),
        .rx_data (rx_data),
        .miso    (miso),
        .spi     (spi)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_mismatch(input string msg);
        error_count++;
        $display("MISMATCH at %0t ns: %s", $time, msg);
        $display("Something failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_error(input string msg);
        error_count++;
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("Something failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic load_trace();
        int    fd;
        int    n;
        int    id;
        int    wr;
        int    slv;
        string line;
        fd = $fopen("dv/spi_trace.txt", "r");
        if (fd == 0) begin
            report_error("cannot open dv/spi_trace.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // Comment and blank lines carry no transfer
            if (n > 0 && line[0] != "#" && $sscanf(line, "%d %h %h", id, wr, slv) == 3) begin
                trace_id.push_back(id);
                trace_wr.push_back(wr[7:0]);
                trace_slv.push_back(slv[7:0]);
            end
        end
        $fclose(fd);
        if (trace_id.size() == 0) begin
            report_error("trace file holds no transfers");
        end
    endtask

    task automatic wait_rx_count(input int target, input int limit);
        int n;
        n = 0;
        while (rx_count < target) begin
            @(negedge clk);
            n++;
            if (n > limit) begin
                report_error("timeout waiting for rx_valid pulses of the burst");
            end
        end
    endtask

    task automatic wait_cs_high(input int limit);
        int n;
        n = 0;
        while (!spi.cs_n) begin
            @(negedge clk);
            n++;
            if (n > limit) begin
                report_error("timeout waiting for cs_n to return high");
            end
        end
    endtask

    // Bus idle, no transfer outstanding
    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            assert (spi.cs_n && spi.sclk)
                else report_mismatch("cs_n or sclk low while idle");
            assert (!spi.mosi) else report_mismatch("mosi high while idle");
            assert (!rx_valid) else report_mismatch("rx_valid while nothing was written");
            assert (!full) else report_mismatch("full high while idle");
        end
    endtask

    // Writes one burst in consecutive cycles, then waits for it to drain
    task automatic run_burst(input int first, input int last);
        int   k;
        int   target;
        logic full_seen;
        target    = rx_count;
        full_seen = 1'b0;
        for (k = first; k < last; k++) begin
            @(negedge clk);
            // Full at this edge means the write is dropped
            if (full) begin
                full_seen = 1'b1;
            end else begin
                exp_mosi.push_back(trace_wr[k]);
                exp_rx.push_back(trace_slv[k]);
                slv_q.push_back(trace_slv[k]);
                target++;
            end
            wr_en   = 1'b1;
            wr_data = trace_wr[k];
        end
        @(negedge clk);
        wr_en   = 1'b0;
        wr_data = '0;
        if (full) begin
            full_seen = 1'b1;
        end
        if (last - first > DEPTH) begin
            assert (full_seen) else report_error("full never rose during a long burst");
        end
        wait_rx_count(target, (target - rx_count) * BYTE_TIMEOUT + 50);
        wait_cs_high(BYTE_TIMEOUT);
    endtask

    // Slave model and output monitor
    always @(negedge clk) begin
        spi_byte_t want;
        if (!rst) begin
            // Clock parked high outside a frame
            if (spi.cs_n) begin
                assert (spi.sclk) else report_mismatch("sclk low while cs_n high");
            end
            if (in_burst) begin
                assert (!spi.cs_n) else report_mismatch("cs_n rose inside a burst");
            end
            if (cs_check_due) begin
                assert (spi.cs_n == cs_expect_high)
                    else report_mismatch($sformatf("cs_n %0b after rx_valid, expected %0b",
                                                   spi.cs_n, cs_expect_high));
                cs_check_due = 1'b0;
            end
            // Falling sclk inside the frame
            if (!spi.cs_n && prev_sclk && !spi.sclk) begin
                fall_cnt++;
                in_burst = 1'b1;
            end
            // Rising sclk, slave takes mosi and moves to its next bit
            if (!spi.cs_n && !prev_sclk && spi.sclk) begin
                slv_rx = {slv_rx[6:0], spi.mosi};
                slv_bits++;
                if (slv_bits == 8) begin
                    assert (exp_mosi.size() > 0)
                        else report_mismatch("byte on mosi that was never accepted");
                    want = exp_mosi.pop_front();
                    assert (slv_rx == want)
                        else report_mismatch($sformatf("mosi byte %02h, expected %02h",
                                                       slv_rx, want));
                    slv_bits = 0;
                    if (slv_q.size() > 0) begin
                        void'(slv_q.pop_front());
                    end
                end
            end
            // MSB first, held until the master samples it
            if (slv_q.size() == 0) begin
                miso = 1'b0;
            end else begin
                miso = slv_q[0][7 - slv_bits];
            end
            if (rx_valid) begin
                assert (exp_rx.size() > 0)
                    else report_mismatch("rx_valid with no transfer outstanding");
                want = exp_rx.pop_front();
                assert (rx_data == want)
                    else report_mismatch($sformatf("rx_data %02h, expected %02h", rx_data, want));
                assert (fall_cnt == 8)
                    else report_mismatch($sformatf("%0d sclk low pulses in a byte, expected 8",
                                                   fall_cnt));
                fall_cnt       = 0;
                rx_count++;
                cs_check_due   = 1'b1;
                cs_expect_high = (exp_rx.size() == 0);
                // Last byte of the burst
                if (exp_rx.size() == 0) begin
                    in_burst = 1'b0;
                end
            end
        end
        prev_sclk = spi.sclk;
    end

    initial begin
        int i;
        int j;
        rst            = 1'b1;
        wr_en          = 1'b0;
        wr_data        = '0;
        miso           = 1'b0;
        rx_count       = 0;
        error_count    = 0;
        fall_cnt       = 0;
        slv_bits       = 0;
        slv_rx         = '0;
        prev_sclk      = 1'b1;
        in_burst       = 1'b0;
        cs_check_due   = 1'b0;
        cs_expect_high = 1'b1;
        load_trace();
        repeat (16) @(negedge clk);
        rst = 1'b0;
        check_idle(10);
        // Consecutive lines with one id form a burst
        i = 0;
        while (i < trace_id.size()) begin
            j = i;
            while (j < trace_id.size() && trace_id[j] == trace_id[i]) begin
                j++;
            end
            run_burst(i, j);
            check_idle(4);
            i = j;
        end
        assert (exp_mosi.size() == 0 && exp_rx.size() == 0)
            else report_error("transfers still outstanding at end of trace");
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/spi_trace.txt
# burst_id  host_byte  slave_byte, bytes in hex
# Lines sharing a burst id are written back to back as one burst
0 a5 3c
1 01 80
2 ff 00
3 00 ff
4 12 ed
4 34 cb
4 56 a9
4 78 87
5 c3 5a
5 96 e1
5 0f 7e
5 f0 24
5 3b 99
5 d2 66
6 81 18
7 aa 55
7 55 aa
7 e7 7e
8 de ad
8 be ef
8 ca fe
8 ba be
9 10 f1
9 20 e2
9 30 d3
9 40 c4
9 50 b5
9 60 a6
10 6d 92
10 b4 4b
11 99 c6

//--- logic/spi_frame_ctrl.sv
`default_nettype none

module spi_frame_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 empty,
    input  spi_pkg::spi_status_t status,
    output logic                 pop,
    output logic                 start,
    output logic                 cs_n
);

    typedef enum logic [1:0] {
        ST_WAIT,
        ST_SHIFT,
        ST_GAP
    } state_t;

    state_t state;
    state_t state_next;
    logic   issue;

    // Next byte goes out only from wait or gap, with data ready and engine idle
    assign issue = ((state == ST_WAIT) || (state == ST_GAP)) && !empty && !status.busy;

    // Head leaves the queue in the same cycle the engine loads it
    assign pop   = issue;
    assign start = issue;

    always_comb begin
        state_next = state;
        case (state)
            ST_WAIT: begin
                if (issue) begin
                    state_next = ST_SHIFT;
                end
            end

            ST_SHIFT: begin
                // Decide at done whether the burst continues
                if (status.done) begin
                    state_next = empty ? ST_WAIT : ST_GAP;
                end
            end

            ST_GAP: begin
                state_next = issue ? ST_SHIFT : ST_WAIT;
            end

            default: begin
                state_next = ST_WAIT;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_WAIT;
            cs_n  <= 1'b1;
        end else begin
            state <= state_next;
            // Low from the first pop, high again once the burst ends
            if (issue) begin
                cs_n <= 1'b0;
            end else if (state_next == ST_WAIT) begin
                cs_n <= 1'b1;
            end
        end
    end

    // Slave stays selected from the first serial edge through the done cycle
    a_busy_cs: assert property (@(posedge clk) disable iff (rst) status.busy |-> !cs_n)
        else $error("chip select high while engine busy");

endmodule

`default_nettype wire

//--- logic/spi_master_top.sv
`default_nettype none

module spi_master_top #(
    parameter int clk_div = spi_pkg::SPI_CLK_DIV_DEFAULT,
    parameter int depth   = spi_pkg::QUEUE_DEPTH_DEFAULT
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               wr_en,
    input  spi_pkg::spi_byte_t wr_data,
    output logic               full,
    output logic               rx_valid,
    output spi_pkg::spi_byte_t rx_data,
    input  logic               miso,
    output spi_pkg::spi_pins_t spi
);
    import spi_pkg::*;

    spi_byte_t   q_rd_data;
    logic        q_empty;
    logic        q_pop;
    logic        eng_start;
    logic        ctrl_cs_n;
    spi_status_t eng_status;
    spi_pins_t   eng_pins;

    // Host write queue
    spi_tx_queue #(
        .depth(depth)
    ) u_queue (
        .clk      (clk),
        .rst      (rst),
        .push     (wr_en),
        .push_data(wr_data),
        .pop      (q_pop),
        .rd_data  (q_rd_data),
        .empty    (q_empty),
        .full     (full)
    );

    // Burst sequencing and chip select
    spi_frame_ctrl u_ctrl (
        .clk   (clk),
        .rst   (rst),
        .empty (q_empty),
        .status(eng_status),
        .pop   (q_pop),
        .start (eng_start),
        .cs_n  (ctrl_cs_n)
    );

    // Byte shifter on the serial pins
    spi_shift_engine #(
        .clk_div(clk_div)
    ) u_engine (
        .clk    (clk),
        .rst    (rst),
        .start  (eng_start),
        .tx_data(q_rd_data),
        .miso   (miso),
        .pins   (eng_pins),
        .status (eng_status),
        .rx_data(rx_data)
    );

    // Pin merge, either source may hold chip select high
    assign spi.sclk = eng_pins.sclk;
    assign spi.mosi = eng_pins.mosi;
    assign spi.cs_n = eng_pins.cs_n & ctrl_cs_n;

    // Received byte valid for one cycle
    assign rx_valid = eng_status.done;

endmodule

`default_nettype wire

//--- logic/spi_pkg.sv
`default_nettype none

package spi_pkg;

    // One serial transfer word
    typedef logic [7:0] spi_byte_t;

    // Outgoing serial pins
    // Engine fills sclk and mosi, the frame controller fills cs_n
    typedef struct packed {
        logic sclk;
        logic mosi;
        logic cs_n;
    } spi_pins_t;

    // Engine report to the frame controller
    // busy covers transfer and done, done is a single-cycle pulse
    typedef struct packed {
        logic busy;
        logic done;
    } spi_status_t;

    // System cycles per serial half-period
    localparam int SPI_CLK_DIV_DEFAULT = 1;

    // Transmit queue entries
    localparam int QUEUE_DEPTH_DEFAULT = 4;

endpackage

`default_nettype wire

//--- logic/spi_shift_engine.sv
`default_nettype none

module spi_shift_engine #(
    parameter int clk_div = spi_pkg::SPI_CLK_DIV_DEFAULT
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  spi_pkg::spi_byte_t   tx_data,
    input  logic                 miso,
    output spi_pkg::spi_pins_t   pins,
    output spi_pkg::spi_status_t status,
    output spi_pkg::spi_byte_t   rx_data
);
    import spi_pkg::*;

    // Prescale counter width, at least one bit
    localparam int PW = (clk_div > 1) ? $clog2(clk_div) : 1;
    localparam logic [PW-1:0] PRE_LAST = PW'(clk_div - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_XFER,
        ST_DONE
    } state_t;

    state_t        state;
    state_t        state_next;
    logic [3:0]    edge_cnt;
    logic [3:0]    edge_cnt_next;
    logic [PW-1:0] pre_cnt;
    logic [PW-1:0] pre_cnt_next;
    spi_byte_t     tx_sr;
    spi_byte_t     tx_sr_next;
    spi_byte_t     rx_sr;
    spi_byte_t     rx_sr_next;
    logic          tick;

    // One tick per serial half-period
    assign tick = (pre_cnt == PRE_LAST);

    // Control state and transmit shifter
    // tx_sr reset keeps mosi low after reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= ST_IDLE;
            edge_cnt <= '0;
            pre_cnt  <= '0;
            tx_sr    <= '0;
        end else begin
            state    <= state_next;
            edge_cnt <= edge_cnt_next;
            pre_cnt  <= pre_cnt_next;
            tx_sr    <= tx_sr_next;
        end
    end

    // Receive shifter and result byte
    always_ff @(posedge clk) begin
        rx_sr <= rx_sr_next;
        // Capture the complete byte on entry to done
        if (state_next == ST_DONE) begin
            rx_data <= rx_sr_next;
        end
    end

    always_comb begin
        state_next    = state;
        edge_cnt_next = edge_cnt;
        pre_cnt_next  = pre_cnt;
        tx_sr_next    = tx_sr;
        rx_sr_next    = rx_sr;

        case (state)
            ST_IDLE: begin
                if (start) begin
                    state_next    = ST_XFER;
                    tx_sr_next    = tx_data;
                    rx_sr_next    = '0;
                    // 16 half-periods, counted down
                    edge_cnt_next = 4'd15;
                    pre_cnt_next  = '0;
                end
            end

            ST_XFER: begin
                if (tick) begin
                    pre_cnt_next  = '0;
                    edge_cnt_next = edge_cnt - 4'd1;
                    if (edge_cnt[0]) begin
                        // Odd count, sclk low after a falling edge
                        // Slave data is stable here
                        rx_sr_next = {rx_sr[6:0], miso};
                    end else begin
                        // Even count, sclk high
                        // Next bit appears as sclk falls again
                        tx_sr_next = {tx_sr[6:0], 1'b0};
                    end
                    // Last half-period ends the byte
                    if (edge_cnt == 4'd0) begin
                        state_next = ST_DONE;
                    end
                end else begin
                    pre_cnt_next = pre_cnt + 1'b1;
                end
            end

            ST_DONE: begin
                state_next = ST_IDLE;
            end

            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    // Clock idles high, low on odd counts and high on even counts
    assign pins.sclk = (state == ST_XFER) ? ~edge_cnt[0] : 1'b1;
    // MSB first straight from the shifter
    assign pins.mosi = tx_sr[7];
    // Chip select belongs to the frame controller
    assign pins.cs_n = 1'b1;

    assign status.busy = (state != ST_IDLE);
    assign status.done = (state == ST_DONE);

    // Controller must wait for idle before the next byte
    a_start_idle: assert property (@(posedge clk) disable iff (rst) start |-> !status.busy)
        else $error("start seen while engine busy");

endmodule

`default_nettype wire

//--- logic/spi_tx_queue.sv
`default_nettype none

module spi_tx_queue #(
    parameter int depth = spi_pkg::QUEUE_DEPTH_DEFAULT
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               push,
    input  spi_pkg::spi_byte_t push_data,
    input  logic               pop,
    output spi_pkg::spi_byte_t rd_data,
    output logic               empty,
    output logic               full
);
    import spi_pkg::*;

    // Pointer and occupancy widths
    localparam int AW = (depth > 1) ? $clog2(depth) : 1;
    localparam int CW = $clog2(depth + 1);
    localparam logic [AW-1:0] PTR_LAST = AW'(depth - 1);
    localparam logic [CW-1:0] CNT_MAX = CW'(depth);

    spi_byte_t     mem [depth];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_push;
    logic          do_pop;

    // Write into a full queue is dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Storage array
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap at depth, so depth need not be a power of two
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head is visible whenever the queue is not empty
    assign rd_data = mem[rd_ptr];
    assign empty   = (count == '0);
    assign full    = (count == CNT_MAX);

    // Controller only pops a non-empty queue
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("queue popped while empty");

    a_count_bound: assert property (@(posedge clk) disable iff (rst) count <= CNT_MAX)
        else $error("queue occupancy above depth");

endmodule

`default_nettype wire
